/* hw/dispatch_ctrl.sv */
////////////////////////////////////////
// Dispatch control of the lane sequencer
// Decides when the held request issues, splits its length
// over the lanes, tracks running IDs and drives the unit
// operation and the done reports
////////////////////////////////////////

`timescale 1ns/10ps

`include "lane_seq_macros.svh"

module dispatch_ctrl import lane_seq_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lane_id_t              lane_id_i,
  // Held request and its issue strobe
  input  pe_req_t               req_i,
  input  logic                  req_valid_i,
  output logic                  req_issue_o,
  // Lane share of the instruction
  output vlen_t                 lane_vl_o,
  output vlen_t                 lane_vstart_o,
  // Operand slots still waiting for their queue
  input  logic [`NR_OPQ-1:0]    slot_valid_i,
  // Main sequencer status and responses
  input  logic [`NR_VINSN-1:0]  pe_vinsn_running_i,
  input  logic [`NR_VINSN-1:0]  alu_vinsn_done_i,
  input  logic [`NR_VINSN-1:0]  mfpu_vinsn_done_i,
  output logic [`NR_VINSN-1:0]  pe_resp_done_o,
  output logic                  alu_vinsn_done_o,
  output logic                  mfpu_vinsn_done_o,
  // Operation for the functional units
  output vfu_op_t               vfu_operation_o,
  output logic                  vfu_operation_valid_o
);

  logic [`NR_OPQ-1:0]   slots_needed;
  logic [`NR_VINSN-1:0] running_q;
  logic [`NR_VINSN-1:0] running_now;
  logic [`NR_VINSN-1:0] running_d;
  logic [`NR_VINSN-1:0] done_d;
  logic                 muted;
  vfu_op_t              op_d;

  ////////////////////////////////////////
  // Lane length split
  ////////////////////////////////////////

  // Elements are striped over the lanes, and the low lanes take the remainder
  always_comb begin
    lane_vl_o = vlen_t'(req_i.vl / `NR_LANES);
    if (lane_id_i < req_i.vl[$bits(lane_id_t)-1:0]) begin
      lane_vl_o = lane_vl_o + 1'b1;
    end
    lane_vstart_o = vlen_t'(req_i.vstart / `NR_LANES);
  end

  // Nothing to execute in this lane
  assign muted = (lane_vl_o == '0);

  ////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////

  // Each unit stalls on its own operand slots and on the shared mask slot
  always_comb begin
    slots_needed         = '0;
    slots_needed[MASK_M] = 1'b1;
    case (req_i.vfu)
      VFU_ALU: begin
        slots_needed[ALU_A] = 1'b1;
        slots_needed[ALU_B] = 1'b1;
      end
      VFU_MFPU: begin
        slots_needed[MFPU_A] = 1'b1;
        slots_needed[MFPU_B] = 1'b1;
        slots_needed[MFPU_C] = 1'b1;
      end
      default: ;
    endcase
  end

  // The main sequencer clears running bits of retired instructions
  assign running_now = running_q & pe_vinsn_running_i;

  // A request whose ID still runs waits for that ID to retire
  assign req_issue_o = req_valid_i && ((slot_valid_i & slots_needed) == '0) &&
                       !running_now[req_i.id];

  ////////////////////////////////////////
  // Bookkeeping and operation
  ////////////////////////////////////////

  always_comb begin
    running_d = running_now;
    done_d    = alu_vinsn_done_i | mfpu_vinsn_done_i;
    // A muted instruction is finished here as soon as it issues
    if (req_issue_o) begin
      if (muted) begin
        done_d[req_i.id] = 1'b1;
      end else begin
        running_d[req_i.id] = 1'b1;
      end
    end
  end

  // Copy the request fields and attach the lane window
  always_comb begin
    op_d.id            = req_i.id;
    op_d.op            = req_i.op;
    op_d.vfu           = req_i.vfu;
    op_d.vm            = req_i.vm;
    op_d.use_vs1       = req_i.use_vs1;
    op_d.use_vs2       = req_i.use_vs2;
    op_d.use_vd_op     = req_i.use_vd_op;
    op_d.use_scalar_op = req_i.use_scalar_op;
    op_d.scalar_op     = req_i.scalar_op;
    op_d.vd            = req_i.vd;
    op_d.vsew          = req_i.vsew;
    op_d.vl            = lane_vl_o;
    op_d.vstart        = lane_vstart_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q             <= '0;
      pe_resp_done_o        <= '0;
      alu_vinsn_done_o      <= 1'b0;
      mfpu_vinsn_done_o     <= 1'b0;
      vfu_operation_valid_o <= 1'b0;
    end else begin
      running_q             <= running_d;
      pe_resp_done_o        <= done_d;
      alu_vinsn_done_o      <= |alu_vinsn_done_i;
      mfpu_vinsn_done_o     <= |mfpu_vinsn_done_i;
      vfu_operation_valid_o <= req_issue_o && !muted;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_issue_o && !muted) begin
      vfu_operation_o <= op_d;
    end
  end

  // The ID on the strobe is now marked running, so a second copy of it
  // stalls until the main sequencer retires the first one
  a_id_not_running : assert property (@(posedge clk_i) disable iff (!rst_ni)
    vfu_operation_valid_o |-> running_q[vfu_operation_o.id])
    else $error("Issued operation not tracked as running");

endmodule

/* hw/lane_seq_macros.svh */
////////////////////////////////////////
// Size constants of the lane sequencer
// Include this header wherever lane counts, ID counts
// or field widths set a port or a loop bound
////////////////////////////////////////

`ifndef LANE_SEQ_MACROS_SVH
`define LANE_SEQ_MACROS_SVH

// Number of lanes that share one broadcast request
`define NR_LANES 4
// Number of vector instruction IDs that can be in flight
`define NR_VINSN 8
// Width of the vector length and start element fields
`define VL_W 16
// Width of a vector register index
`define VREG_W 5
// Operand queues served by this lane sequencer
`define NR_OPQ 6

`endif

/* hw/lane_seq_pkg.sv */
////////////////////////////////////////
// Shared types of the lane sequencer
// Holds the unit, opcode, element width and queue enums
// and the request, operation and command structs
////////////////////////////////////////

`include "lane_seq_macros.svh"

package lane_seq_pkg;

  // Instruction ID and lane index
  typedef logic [$clog2(`NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`NR_LANES)-1:0] lane_id_t;

  // Length and register index fields
  typedef logic [`VL_W-1:0]   vlen_t;
  typedef logic [`VREG_W-1:0] vreg_t;

  // Functional unit that executes an instruction
  typedef enum logic {
    VFU_ALU,
    VFU_MFPU
  } vfu_e;

  // The first four run on the ALU, the rest on the multiplier/FPU
  typedef enum logic [3:0] {
    VADD, VSUB, VAND, VOR,
    VMUL, VMACC, VFADD, VFMUL
  } op_e;

  // Element width of the vector type
  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } sew_e;

  // Operand queue index, also the bit position in the valid vectors
  typedef enum logic [2:0] {
    ALU_A, ALU_B, MFPU_A, MFPU_B, MFPU_C, MASK_M
  } opq_e;

  // Request broadcast by the main sequencer
  typedef struct packed {
    vid_t        id;
    op_e         op;
    vfu_e        vfu;
    logic        vm;
    logic        use_vs1;
    logic        use_vs2;
    logic        use_vd_op;
    logic        use_scalar_op;
    logic [63:0] scalar_op;
    vreg_t       vs1;
    vreg_t       vs2;
    vreg_t       vd;
    sew_e        vsew;
    vlen_t       vl;
    vlen_t       vstart;
  } pe_req_t;

  // Operation handed to the lane's functional units
  typedef struct packed {
    vid_t        id;
    op_e         op;
    vfu_e        vfu;
    logic        vm;
    logic        use_vs1;
    logic        use_vs2;
    logic        use_vd_op;
    logic        use_scalar_op;
    logic [63:0] scalar_op;
    vreg_t       vd;
    sew_e        vsew;
    vlen_t       vl;
    vlen_t       vstart;
  } vfu_op_t;

  // Command for one operand queue
  typedef struct packed {
    vid_t  id;
    vreg_t vs;
    sew_e  vsew;
    vlen_t vl;
    vlen_t vstart;
  } opq_cmd_t;

endpackage

/* hw/lane_sequencer.sv */
////////////////////////////////////////
// Sequencer of one vector lane
// Takes broadcast requests, issues unit operations and
// operand commands and reports finished instructions
////////////////////////////////////////

`timescale 1ns/10ps

`include "lane_seq_macros.svh"

module lane_sequencer import lane_seq_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  lane_id_t                  lane_id_i,
  // Main sequencer side
  input  pe_req_t                   pe_req_i,
  input  logic                      pe_req_valid_i,
  output logic                      pe_req_ready_o,
  input  logic     [`NR_VINSN-1:0]  pe_vinsn_running_i,
  output logic     [`NR_VINSN-1:0]  pe_resp_done_o,
  // Operand requesters
  output opq_cmd_t [`NR_OPQ-1:0]    operand_request_o,
  output logic     [`NR_OPQ-1:0]    operand_request_valid_o,
  input  logic     [`NR_OPQ-1:0]    operand_request_ready_i,
  // Functional units
  output vfu_op_t                   vfu_operation_o,
  output logic                      vfu_operation_valid_o,
  input  logic     [`NR_VINSN-1:0]  alu_vinsn_done_i,
  input  logic     [`NR_VINSN-1:0]  mfpu_vinsn_done_i,
  output logic                      alu_vinsn_done_o,
  output logic                      mfpu_vinsn_done_o
);

  // Held request and its issue strobe
  pe_req_t                req;
  logic                   req_valid;
  logic                   req_issue;
  // Lane share of the issuing instruction
  vlen_t                  lane_vl;
  vlen_t                  lane_vstart;
  // Commands on their way to the slots
  opq_cmd_t [`NR_OPQ-1:0] cmd;
  logic     [`NR_OPQ-1:0] push;

  req_filter u_filter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .req_o          (req),
    .req_valid_o    (req_valid),
    .req_issue_i    (req_issue)
  );

  dispatch_ctrl u_dispatch (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .lane_id_i             (lane_id_i),
    .req_i                 (req),
    .req_valid_i           (req_valid),
    .req_issue_o           (req_issue),
    .lane_vl_o             (lane_vl),
    .lane_vstart_o         (lane_vstart),
    .slot_valid_i          (operand_request_valid_o),
    .pe_vinsn_running_i    (pe_vinsn_running_i),
    .alu_vinsn_done_i      (alu_vinsn_done_i),
    .mfpu_vinsn_done_i     (mfpu_vinsn_done_i),
    .pe_resp_done_o        (pe_resp_done_o),
    .alu_vinsn_done_o      (alu_vinsn_done_o),
    .mfpu_vinsn_done_o     (mfpu_vinsn_done_o),
    .vfu_operation_o       (vfu_operation_o),
    .vfu_operation_valid_o (vfu_operation_valid_o)
  );

  operand_cmd_gen u_cmd_gen (
    .req_i         (req),
    .lane_id_i     (lane_id_i),
    .lane_vl_i     (lane_vl),
    .lane_vstart_i (lane_vstart),
    .issue_i       (req_issue),
    .cmd_o         (cmd),
    .push_o        (push)
  );

  operand_cmd_slots u_slots (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .cmd_i                   (cmd),
    .push_i                  (push),
    .operand_request_o       (operand_request_o),
    .operand_request_valid_o (operand_request_valid_o),
    .operand_request_ready_i (operand_request_ready_i)
  );

endmodule

/* hw/operand_cmd_gen.sv */
////////////////////////////////////////
// Operand command builder of the lane sequencer
// Turns an issuing request into one command per operand
// queue together with the push bits for the slots
////////////////////////////////////////

`timescale 1ns/10ps

`include "lane_seq_macros.svh"

module operand_cmd_gen import lane_seq_pkg::*; (
  input  pe_req_t                   req_i,
  input  lane_id_t                  lane_id_i,
  input  vlen_t                     lane_vl_i,
  input  vlen_t                     lane_vstart_i,
  input  logic                      issue_i,
  output opq_cmd_t [`NR_OPQ-1:0]    cmd_o,
  output logic     [`NR_OPQ-1:0]    push_o
);

  logic  muted;
  vlen_t mask_vl;

  // This lane gets no element when the whole vector is shorter than the
  // lane count and the lane index is at or past its length
  assign muted = (req_i.vl < `NR_LANES) &&
                 (lane_id_i >= req_i.vl[$bits(lane_id_t)-1:0]);

  // The mask queue reads whole 64-bit words spread over all lanes,
  // so its length follows the full vector length and not the lane share
  always_comb begin
    mask_vl = vlen_t'((req_i.vl / (`NR_LANES * 8)) >> req_i.vsew);
    // Round up when the vector ends inside a word
    if (vlen_t'((mask_vl << req_i.vsew) * (`NR_LANES * 8)) != req_i.vl) begin
      mask_vl = mask_vl + 1'b1;
    end
  end

  always_comb begin
    // All commands share the ID, the width and the lane window
    for (int q = 0; q < `NR_OPQ; q++) begin
      cmd_o[q].id     = req_i.id;
      cmd_o[q].vs     = '0;
      cmd_o[q].vsew   = req_i.vsew;
      cmd_o[q].vl     = lane_vl_i;
      cmd_o[q].vstart = lane_vstart_i;
    end

    // Source registers of each queue
    cmd_o[ALU_A].vs  = req_i.vs1;
    cmd_o[ALU_B].vs  = req_i.vs2;
    cmd_o[MFPU_A].vs = req_i.vs1;
    cmd_o[MFPU_B].vs = req_i.vs2;
    cmd_o[MFPU_C].vs = req_i.vd;

    // The mask always lives in register zero
    cmd_o[MASK_M].vs = '0;
    cmd_o[MASK_M].vl = mask_vl;

    push_o = '0;
    case (req_i.vfu)
      VFU_ALU: begin
        push_o[ALU_A] = req_i.use_vs1;
        push_o[ALU_B] = req_i.use_vs2;
      end
      VFU_MFPU: begin
        push_o[MFPU_A] = req_i.use_vs1;
        push_o[MFPU_B] = req_i.use_vs2;
        // Third operand is the old destination, as for a multiply-accumulate
        push_o[MFPU_C] = req_i.use_vd_op;
      end
      default: ;
    endcase
    // Masked instructions fetch the mask for either unit
    push_o[MASK_M] = !req_i.vm;

    // Nothing is requested unless the instruction really runs here
    if (!issue_i || muted) begin
      push_o = '0;
    end
  end

endmodule

/* hw/operand_cmd_slots.sv */
////////////////////////////////////////
// Operand request slots of the lane sequencer
// Holds one command per operand queue until the queue's
// requester takes it with its ready
////////////////////////////////////////

`timescale 1ns/10ps

`include "lane_seq_macros.svh"

module operand_cmd_slots import lane_seq_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // New commands from the builder
  input  opq_cmd_t [`NR_OPQ-1:0]    cmd_i,
  input  logic     [`NR_OPQ-1:0]    push_i,
  // Towards the operand requesters
  output opq_cmd_t [`NR_OPQ-1:0]    operand_request_o,
  output logic     [`NR_OPQ-1:0]    operand_request_valid_o,
  input  logic     [`NR_OPQ-1:0]    operand_request_ready_i
);

  opq_cmd_t [`NR_OPQ-1:0] slot_q;
  logic     [`NR_OPQ-1:0] valid_q;

  // Ready clears a slot, a push in the same cycle refills it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= push_i | (valid_q & ~operand_request_ready_i);
    end
  end

  // Command payload only moves on a push
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < `NR_OPQ; q++) begin
      if (push_i[q]) begin
        slot_q[q] <= cmd_i[q];
      end
    end
  end

  assign operand_request_o       = slot_q;
  assign operand_request_valid_o = valid_q;

  // The dispatch stall keeps pushes away from slots that still wait
  a_no_overwrite : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i & valid_q & ~operand_request_ready_i) == '0)
    else $error("Operand command pushed over a pending slot");

endmodule

/* hw/req_filter.sv */
////////////////////////////////////////
// Request register in front of the lane sequencer
// Samples each broadcast instruction once and holds it
// in a fall-through register until it issues
////////////////////////////////////////

`timescale 1ns/10ps

module req_filter import lane_seq_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Broadcast request from the main sequencer
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output logic    pe_req_ready_o,
  // Held request towards the dispatch logic
  output pe_req_t req_o,
  output logic    req_valid_o,
  input  logic    req_issue_i
);

  // Duplicate filter state
  vid_t    last_id_q;
  logic    sync_q;
  logic    valid_msk;
  logic    req_xfer;

  // Fall-through storage
  pe_req_t data_q;
  logic    full_q;
  logic    load;

  // A broadcast stays valid until every lane has taken it, so the ID of the
  // last accepted request is masked off while that broadcast lasts
  assign valid_msk = pe_req_valid_i && !(sync_q && (pe_req_i.id == last_id_q));

  // Room for a new request when empty or when the held one leaves now
  assign pe_req_ready_o = !full_q || req_issue_i;
  assign req_xfer       = valid_msk && pe_req_ready_o;

  // An empty register passes the incoming request straight through
  assign req_o       = full_q ? data_q : pe_req_i;
  assign req_valid_o = full_q || valid_msk;

  // Store the input unless it falls through and issues in the same cycle
  assign load = req_xfer && (full_q || !req_issue_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q    <= 1'b0;
      sync_q    <= 1'b0;
      last_id_q <= '0;
    end else begin
      if (load) begin
        full_q <= 1'b1;
      end else if (req_issue_i) begin
        full_q <= 1'b0;
      end
      // Remember the accepted ID until the sequencer drops its valid
      if (req_xfer) begin
        last_id_q <= pe_req_i.id;
        sync_q    <= 1'b1;
      end else if (!pe_req_valid_i) begin
        sync_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= pe_req_i;
    end
  end

  // A broadcast held over two cycles is never taken twice
  a_no_double_sample : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_xfer && pe_req_valid_i) |=> !(req_xfer && (pe_req_i.id == $past(pe_req_i.id))))
    else $error("Broadcast request sampled twice");

endmodule

/* tb.f */
+incdir+hw
hw/lane_seq_pkg.sv
hw/req_filter.sv
hw/operand_cmd_gen.sv
hw/operand_cmd_slots.sv
hw/dispatch_ctrl.sv
hw/lane_sequencer.sv
verif/tb_lane_sequencer.sv

/* verif/tb_lane_sequencer.sv */
////////////////////////////////////////
// Testbench of the lane sequencer
// Broadcasts random requests to lane 2 and checks the unit
// operations, operand commands and done reports against a model
////////////////////////////////////////

`timescale 1ns/10ps

`include "lane_seq_macros.svh"

module tb_lane_sequencer import lane_seq_pkg::*; ();

  localparam int          NR_REQ     = 300;
  localparam int          MAX_CYCLES = 200 * NR_REQ;
  localparam logic [31:0] SEED       = 32'ha2a7;
  localparam lane_id_t    LANE_ID    = 2'd2;

  logic                   clk_i;
  logic                   rst_ni;
  pe_req_t                pe_req;
  logic                   pe_req_valid;
  logic                   pe_req_ready;
  logic [`NR_VINSN-1:0]   vinsn_running;
  logic [`NR_VINSN-1:0]   resp_done;
  opq_cmd_t [`NR_OPQ-1:0] opq_cmd;
  logic [`NR_OPQ-1:0]     opq_valid;
  logic [`NR_OPQ-1:0]     opq_ready;
  vfu_op_t                vfu_op;
  logic                   vfu_op_valid;
  logic [`NR_VINSN-1:0]   alu_done_in;
  logic [`NR_VINSN-1:0]   mfpu_done_in;
  logic                   alu_done_out;
  logic                   mfpu_done_out;

  ////////////////////////////////////////
  // Model state
  ////////////////////////////////////////

  logic [31:0]          lcg_state;
  // Accepted requests in issue order and expected commands per queue
  pe_req_t              exp_req_q[$];
  opq_cmd_t             exp_cmd_q[`NR_OPQ][$];
  // Slots that were valid and not taken at the last edge
  logic [`NR_OPQ-1:0]   slot_held;
  opq_cmd_t             slot_seen[`NR_OPQ];
  logic [`NR_VINSN-1:0] done_or_prev;
  logic                 alu_or_prev;
  logic                 mfpu_or_prev;
  // Retirement stage per ID where 1 clears the running bit and 2 frees the ID
  logic [`NR_VINSN-1:0] id_busy;
  int                   done_wait[`NR_VINSN];
  vfu_e                 done_unit[`NR_VINSN];
  int                   retire_stage[`NR_VINSN];
  // Broadcast state is 0 when idle, 1 while offered and 2 while held after the transfer
  int                   bcast_state;
  int                   hold_left;
  int                   sent;
  int                   accepted;
  int                   cycles;
  int                   next_id;
  pe_req_t              cur_req;

  lane_sequencer uut (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .lane_id_i               (LANE_ID),
    .pe_req_i                (pe_req),
    .pe_req_valid_i          (pe_req_valid),
    .pe_req_ready_o          (pe_req_ready),
    .pe_vinsn_running_i      (vinsn_running),
    .pe_resp_done_o          (resp_done),
    .operand_request_o       (opq_cmd),
    .operand_request_valid_o (opq_valid),
    .operand_request_ready_i (opq_ready),
    .vfu_operation_o         (vfu_op),
    .vfu_operation_valid_o   (vfu_op_valid),
    .alu_vinsn_done_i        (alu_done_in),
    .mfpu_vinsn_done_i       (mfpu_done_in),
    .alu_vinsn_done_o        (alu_done_out),
    .mfpu_vinsn_done_o       (mfpu_done_out)
  );

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Steps the 32-bit LCG and returns its upper half where the bits cycle slowest
  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // Lane 2 gets a quarter of the elements plus one of the remainder
  function automatic vlen_t split_vl(vlen_t vl);
    vlen_t share;
    share = vlen_t'(int'(vl) / `NR_LANES);
    if (int'(LANE_ID) < int'(vl) % `NR_LANES) begin
      share = share + 1'b1;
    end
    return share;
  endfunction

  // Mask words of 64 bits span all lanes and a partial word counts as a whole one
  function automatic vlen_t mask_len(vlen_t vl, sew_e sew);
    int words;
    words = (int'(vl) / (`NR_LANES * 8)) >> int'(sew);
    if (((words << int'(sew)) * `NR_LANES * 8) != int'(vl)) begin
      words = words + 1;
    end
    return vlen_t'(words);
  endfunction

  function automatic vfu_op_t expected_op(pe_req_t req);
    vfu_op_t op;
    op.id            = req.id;
    op.op            = req.op;
    op.vfu           = req.vfu;
    op.vm            = req.vm;
    op.use_vs1       = req.use_vs1;
    op.use_vs2       = req.use_vs2;
    op.use_vd_op     = req.use_vd_op;
    op.use_scalar_op = req.use_scalar_op;
    op.scalar_op     = req.scalar_op;
    op.vd            = req.vd;
    op.vsew          = req.vsew;
    op.vl            = split_vl(req.vl);
    op.vstart        = vlen_t'(int'(req.vstart) / `NR_LANES);
    return op;
  endfunction

  // Rotate through the IDs and skip those still in flight
  function automatic int free_id();
    int cand;
    for (int k = 0; k < `NR_VINSN; k++) begin
      cand = (next_id + k) % `NR_VINSN;
      if (!id_busy[cand]) begin
        next_id = cand + 1;
        return cand;
      end
    end
    return -1;
  endfunction

  function automatic pe_req_t random_request(vid_t id);
    pe_req_t     req;
    logic [15:0] r;
    r                 = next_random();
    req.id            = id;
    req.vfu           = vfu_e'(r[0]);
    // MFPU opcodes sit in the upper half of the opcode range
    req.op            = op_e'({1'b0, r[0], r[2:1]});
    req.vm            = r[3];
    req.use_vs1       = r[4];
    req.use_vs2       = r[5];
    req.use_vd_op     = r[6];
    req.use_scalar_op = r[7];
    req.vs1           = r[12:8];
    r                 = next_random();
    req.vs2           = r[4:0];
    req.vd            = r[9:5];
    req.vsew          = sew_e'(r[11:10]);
    req.scalar_op[15:0]  = next_random();
    req.scalar_op[31:16] = next_random();
    req.scalar_op[47:32] = next_random();
    req.scalar_op[63:48] = next_random();
    // A quarter of the vectors are shorter than the lane count
    if (r[13:12] == 2'd0) begin
      req.vl = vlen_t'(r[15:14]);
    end else begin
      req.vl = vlen_t'(next_random() % 300);
    end
    req.vstart        = vlen_t'(next_random() % 64);
    return req;
  endfunction

  // Queue the operation slot and the commands an accepted request must produce
  task automatic record_request(pe_req_t req);
    opq_cmd_t cmd;
    exp_req_q.push_back(req);
    cmd.id     = req.id;
    cmd.vsew   = req.vsew;
    cmd.vl     = split_vl(req.vl);
    cmd.vstart = vlen_t'(int'(req.vstart) / `NR_LANES);
    if (cmd.vl != '0) begin
      if (req.vfu == VFU_ALU) begin
        cmd.vs = req.vs1;
        if (req.use_vs1) exp_cmd_q[ALU_A].push_back(cmd);
        cmd.vs = req.vs2;
        if (req.use_vs2) exp_cmd_q[ALU_B].push_back(cmd);
      end else begin
        cmd.vs = req.vs1;
        if (req.use_vs1) exp_cmd_q[MFPU_A].push_back(cmd);
        cmd.vs = req.vs2;
        if (req.use_vs2) exp_cmd_q[MFPU_B].push_back(cmd);
        cmd.vs = req.vd;
        if (req.use_vd_op) exp_cmd_q[MFPU_C].push_back(cmd);
      end
      if (!req.vm) begin
        cmd.vs = '0;
        cmd.vl = mask_len(req.vl, req.vsew);
        exp_cmd_q[MASK_M].push_back(cmd);
      end
    end
  endtask

  function automatic bit model_idle();
    bit idle;
    idle = (accepted == NR_REQ) && (bcast_state == 0) && (exp_req_q.size() == 0);
    for (int q = 0; q < `NR_OPQ; q++) begin
      idle = idle && (exp_cmd_q[q].size() == 0);
    end
    return idle;
  endfunction

  ////////////////////////////////////////
  // Checks on the rising edge
  ////////////////////////////////////////

  task automatic check_outputs();
    pe_req_t              head;
    opq_cmd_t             want;
    logic [`NR_VINSN-1:0] exp_done;
    if (accepted == 0) begin
      assert (opq_valid == '0 && !vfu_op_valid && resp_done == '0 &&
              !alu_done_out && !mfpu_done_out)
        else stop_on_error($sformatf("Mismatch at %0t: output active before any request",
                                     $time));
    end
    for (int q = 0; q < `NR_OPQ; q++) begin
      if (slot_held[q]) begin
        assert (opq_valid[q] && opq_cmd[q] == slot_seen[q])
          else stop_on_error($sformatf("Mismatch at %0t: slot %0d changed while waiting",
                                       $time, q));
      end
      if (opq_valid[q] && opq_ready[q]) begin
        assert (exp_cmd_q[q].size() > 0)
          else stop_on_error($sformatf("Slot %0d offered a command nobody asked for", q));
        want = exp_cmd_q[q].pop_front();
        assert (opq_cmd[q] == want)
          else stop_on_error($sformatf("Mismatch at %0t: slot %0d gave %h, expected %h",
                                       $time, q, opq_cmd[q], want));
      end
      slot_held[q] = opq_valid[q] && !opq_ready[q];
      slot_seen[q] = opq_cmd[q];
    end
    // One strobe per accepted request in acceptance order
    if (vfu_op_valid) begin
      assert (exp_req_q.size() > 0)
        else stop_on_error("Operation issued while no request was pending");
      head = exp_req_q.pop_front();
      assert (split_vl(head.vl) != '0)
        else stop_on_error($sformatf("Mismatch at %0t: operation issued for muted ID %0d",
                                     $time, head.id));
      assert (vfu_op == expected_op(head))
        else stop_on_error($sformatf("Mismatch at %0t: operation %h, expected %h",
                                     $time, vfu_op, expected_op(head)));
      done_wait[head.id] = 1 + int'(next_random() % 6);
      done_unit[head.id] = head.vfu;
    end
    // A muted request shows up only as an extra done bit
    exp_done = done_or_prev;
    if (!vfu_op_valid && exp_req_q.size() > 0) begin
      head = exp_req_q[0];
      if (split_vl(head.vl) == '0 && resp_done[head.id] && !done_or_prev[head.id]) begin
        void'(exp_req_q.pop_front());
        exp_done[head.id]     = 1'b1;
        retire_stage[head.id] = 1;
      end
    end
    assert (resp_done == exp_done)
      else stop_on_error($sformatf("Mismatch at %0t: done %b, expected %b",
                                   $time, resp_done, exp_done));
    assert (alu_done_out == alu_or_prev && mfpu_done_out == mfpu_or_prev)
      else stop_on_error($sformatf("Mismatch at %0t: unit done flags %b%b, expected %b%b",
                                   $time, alu_done_out, mfpu_done_out,
                                   alu_or_prev, mfpu_or_prev));
    done_or_prev = alu_done_in | mfpu_done_in;
    alu_or_prev  = |alu_done_in;
    mfpu_or_prev = |mfpu_done_in;
    if (bcast_state == 1 && pe_req_valid && pe_req_ready) begin
      record_request(cur_req);
      accepted++;
      bcast_state = 2;
      hold_left   = int'(next_random() % 4);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus on the falling edge
  ////////////////////////////////////////

  task automatic drive_inputs();
    int          id;
    logic [15:0] r;
    alu_done_in  = '0;
    mfpu_done_in = '0;
    for (int i = 0; i < `NR_VINSN; i++) begin
      if (retire_stage[i] == 2) begin
        id_busy[i]      = 1'b0;
        retire_stage[i] = 0;
      end else if (retire_stage[i] == 1) begin
        vinsn_running[i] = 1'b0;
        retire_stage[i]  = 2;
      end
      if (done_wait[i] > 0) begin
        done_wait[i]--;
        if (done_wait[i] == 0) begin
          if (done_unit[i] == VFU_ALU) begin
            alu_done_in[i] = 1'b1;
          end else begin
            mfpu_done_in[i] = 1'b1;
          end
          retire_stage[i] = 1;
        end
      end
    end
    r         = next_random();
    opq_ready = r[`NR_OPQ-1:0];
    if (bcast_state == 2) begin
      if (hold_left > 0) begin
        hold_left--;
      end else begin
        pe_req_valid = 1'b0;
        bcast_state  = 0;
      end
    end else if (bcast_state == 0 && sent < NR_REQ && r[15:14] != 2'd0) begin
      id = free_id();
      if (id >= 0) begin
        cur_req           = random_request(vid_t'(id));
        pe_req            = cur_req;
        pe_req_valid      = 1'b1;
        vinsn_running[id] = 1'b1;
        id_busy[id]       = 1'b1;
        bcast_state       = 1;
        sent++;
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    rst_ni        = 1'b0;
    pe_req        = '0;
    pe_req_valid  = 1'b0;
    vinsn_running = '0;
    alu_done_in   = '0;
    mfpu_done_in  = '0;
    opq_ready     = '0;
    lcg_state     = SEED;
    slot_held     = '0;
    done_or_prev  = '0;
    alu_or_prev   = 1'b0;
    mfpu_or_prev  = 1'b0;
    id_busy       = '0;
    bcast_state   = 0;
    hold_left     = 0;
    sent          = 0;
    accepted      = 0;
    cycles        = 0;
    next_id       = 0;
    for (int i = 0; i < `NR_VINSN; i++) begin
      done_wait[i]    = 0;
      done_unit[i]    = VFU_ALU;
      retire_stage[i] = 0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (!model_idle()) begin
      @(posedge clk_i);
      check_outputs();
      @(negedge clk_i);
      drive_inputs();
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        stop_on_error($sformatf("Timeout after %0d cycles with %0d of %0d requests accepted",
                                cycles, accepted, NR_REQ));
      end
    end
    $display("No errors");
    $finish;
  end

endmodule
